//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_fft_buf
FILELIST  := fft_buf.f
OBJ_DIR   := obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- cp_remover.sv
`timescale 1ns/1ps
`default_nettype none

// strips the cyclic prefix and streams the kept samples into the ping-pong banks
module cp_remover import fft_buf_pkg::*; #(
    parameter int FFT_SIZE = DEF_FFT_SIZE,
    parameter int CP_FIRST = DEF_CP_FIRST,
    parameter int CP_NORM  = DEF_CP_NORM,
    localparam int ADDR_W  = $clog2(FFT_SIZE)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic              in_sym_start,
    input  logic              in_frm_start,
    input  sample_t           in_data,
    input  logic [1:0]        bank_full,    // one flag per bank from the ram
    output logic              wr_en,
    output logic              wr_done,      // last kept sample of the symbol
    output logic              wr_frm,
    output bank_t             wr_bank,
    output logic [ADDR_W-1:0] wr_addr,
    output sample_t           wr_data,
    output logic              overflow      // sticky
);
    localparam int CP_MAX = (CP_FIRST > CP_NORM) ? CP_FIRST : CP_NORM;
    localparam int CNT_W  = $clog2(CP_MAX + FFT_SIZE + 1);
    // idle value, past the end of any symbol
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(CP_MAX + FFT_SIZE);

    logic [CNT_W-1:0] cnt;          // index of the next sample in the symbol
    logic [CNT_W-1:0] cp_len;       // prefix latched at symbol start
    logic             frm_q;        // symbol opened a frame
    logic             skip_q;       // current symbol is being discarded
    bank_t            bank_sel;     // bank the next kept symbol goes to

    logic [CNT_W-1:0] idx, cp_cur, rel;
    logic             frm_cur, keep, first_keep, last_keep, skip;

    always_comb begin
        // a symbol start restarts everything on this very sample
        idx     = in_sym_start ? '0 : cnt;
        cp_cur  = in_sym_start ? (in_frm_start ? CNT_W'(CP_FIRST) : CNT_W'(CP_NORM)) : cp_len;
        frm_cur = in_sym_start ? in_frm_start : frm_q;
        rel     = idx - cp_cur;                  // position inside the fft window
        keep    = in_valid && (idx >= cp_cur) && (rel < CNT_W'(FFT_SIZE));
        first_keep = keep && (rel == '0);
        last_keep  = keep && (rel == CNT_W'(FFT_SIZE - 1));
        // full check happens once, on the first kept sample
        skip    = first_keep ? bank_full[bank_sel] : skip_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= CNT_END;                 // ignore input until the first symbol start
            cp_len   <= CNT_W'(CP_NORM);
            frm_q    <= 1'b0;
            skip_q   <= 1'b0;
            bank_sel <= BANK_PING;
            wr_en    <= 1'b0;
            wr_done  <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (in_valid)
                cnt <= (idx < CNT_END) ? idx + 1'b1 : CNT_END;  // saturate after the window
            if (in_valid && in_sym_start) begin
                cp_len <= cp_cur;
                frm_q  <= in_frm_start;
            end
            if (first_keep)
                skip_q <= bank_full[bank_sel];
            if (first_keep && bank_full[bank_sel])
                overflow <= 1'b1;
            wr_en   <= keep && !skip;
            wr_done <= last_keep && !skip;
            // dropped symbols leave the bank where it is
            if (last_keep && !skip)
                bank_sel <= (bank_sel == BANK_PING) ? BANK_PONG : BANK_PING;
        end
    end

    // write payload, qualified by wr_en
    always_ff @(posedge clk) begin
        wr_bank <= bank_sel;
        wr_addr <= rel[ADDR_W-1:0];
        wr_data <= in_data;
        wr_frm  <= frm_cur;
    end

    // source contract, markers only ride on valid samples
    a_sym_valid: assert property (@(posedge clk) disable iff (rst) in_sym_start |-> in_valid);

endmodule

`default_nettype wire

//--- fft_buf.f
fft_buf_pkg.sv
cp_remover.sv
pingpong_ram.sv
fft_feeder.sv
fft_buf_top.sv
tb_fft_buf.sv

//--- fft_buf_pkg.sv
`default_nettype none

// shared types and default sizing for the cp strip / fft input buffer
package fft_buf_pkg;

    // one complex time-domain sample, 16-bit i in the upper half and q in the lower
    localparam int SAMPLE_W = 32;

    typedef logic [SAMPLE_W-1:0] sample_t;

    // the two halves of the ping-pong store
    typedef enum logic {
        BANK_PING = 1'b0,
        BANK_PONG = 1'b1
    } bank_t;

    // default symbol geometry for the 4k numerology
    localparam int DEF_FFT_SIZE = 4096; // samples per fft symbol
    localparam int DEF_CP_FIRST = 352;  // long prefix of a frame's first symbol
    localparam int DEF_CP_NORM  = 288;  // prefix of every other symbol

    // read slots the fft side grants out of reset
    localparam int DEF_CREDITS  = 8;

endpackage

`default_nettype wire

//--- fft_buf_top.sv
`timescale 1ns/1ps
`default_nettype none

// cp strip, ping-pong store and credit-paced fft feeder
module fft_buf_top import fft_buf_pkg::*; #(
    parameter int FFT_SIZE = DEF_FFT_SIZE,
    parameter int CP_FIRST = DEF_CP_FIRST,
    parameter int CP_NORM  = DEF_CP_NORM,
    parameter int CREDITS  = DEF_CREDITS,
    localparam int ADDR_W  = $clog2(FFT_SIZE)
) (
    input  logic    clk,
    input  logic    rst,
    // real-time sample stream, no back-pressure
    input  logic    in_valid,
    input  sample_t in_data,
    input  logic    in_sym_start,
    input  logic    in_frm_start,
    // fft side
    input  logic    out_credit,
    output logic    out_valid,
    output sample_t out_data,
    output logic    out_sop,
    output logic    out_eop,
    output logic    out_frm_start,
    output logic    overflow
);

    logic              wr_en, wr_done, wr_frm;
    bank_t             wr_bank;
    logic [ADDR_W-1:0] wr_addr;
    sample_t           wr_data;
    logic              rd_en, rd_done, rd_frm;
    bank_t             rd_bank;
    logic [ADDR_W-1:0] rd_addr;
    sample_t           rd_data;
    logic [1:0]        bank_full;            // shared by writer and reader

    cp_remover #(.FFT_SIZE(FFT_SIZE), .CP_FIRST(CP_FIRST), .CP_NORM(CP_NORM)) u_cp_remover (
        .clk, .rst, .in_valid, .in_sym_start, .in_frm_start, .in_data, .bank_full,
        .wr_en, .wr_done, .wr_frm, .wr_bank, .wr_addr, .wr_data, .overflow
    );

    pingpong_ram #(.FFT_SIZE(FFT_SIZE)) u_pingpong_ram (
        .clk, .rst, .wr_en, .wr_done, .wr_frm, .wr_bank, .wr_addr, .wr_data,
        .rd_en, .rd_done, .rd_bank, .rd_addr, .rd_data, .rd_frm, .bank_full
    );

    fft_feeder #(.FFT_SIZE(FFT_SIZE), .CREDITS(CREDITS)) u_fft_feeder (
        .clk, .rst, .bank_full, .rd_data, .rd_frm, .out_credit,
        .rd_en, .rd_done, .rd_bank, .rd_addr,
        .out_valid, .out_sop, .out_eop, .out_frm_start, .out_data
    );

endmodule

`default_nettype wire

//--- fft_feeder.sv
`timescale 1ns/1ps
`default_nettype none

// replays full banks to the fft, paced by credits from the fft side
module fft_feeder import fft_buf_pkg::*; #(
    parameter int FFT_SIZE = DEF_FFT_SIZE,
    parameter int CREDITS  = DEF_CREDITS,
    localparam int ADDR_W  = $clog2(FFT_SIZE)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [1:0]        bank_full,
    input  sample_t           rd_data,
    input  logic              rd_frm,
    input  logic              out_credit,   // one returned slot per cycle high
    output logic              rd_en,
    output logic              rd_done,
    output bank_t             rd_bank,
    output logic [ADDR_W-1:0] rd_addr,
    output logic              out_valid,
    output logic              out_sop,
    output logic              out_eop,
    output logic              out_frm_start,
    output sample_t           out_data
);
    // spare bit so a surplus return shows up instead of wrapping
    localparam int CRED_W = $clog2(CREDITS + 2);

    logic [CRED_W-1:0] credits;             // outstanding slots the fft still accepts

    always_comb begin
        // one read per cycle while the bank is full and a slot is free
        rd_en   = bank_full[rd_bank] && (credits != '0);
        rd_done = rd_en && (rd_addr == ADDR_W'(FFT_SIZE - 1));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(CREDITS);
        end else begin
            credits <= credits + CRED_W'(out_credit) - CRED_W'(rd_en);
        end
    end

    // address walk and bank alternation
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_bank <= BANK_PING;
            rd_addr <= '0;
        end else if (rd_done) begin
            rd_bank <= (rd_bank == BANK_PING) ? BANK_PONG : BANK_PING;
            rd_addr <= '0;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // markers line up with the registered ram output
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_sop   <= 1'b0;
            out_eop   <= 1'b0;
        end else begin
            out_valid <= rd_en;
            out_sop   <= rd_en && (rd_addr == '0);
            out_eop   <= rd_done;
        end
    end

    assign out_data      = rd_data;          // ram already gives the 1-cycle latency
    assign out_frm_start = out_sop && rd_frm; // tag is valid for the whole symbol

    // fft side never hands back more slots than it was given
    a_credit_max: assert property (
        @(posedge clk) disable iff (rst) credits <= CRED_W'(CREDITS)
    );

endmodule

`default_nettype wire

//--- pingpong_ram.sv
`timescale 1ns/1ps
`default_nettype none

// two fft-sized sample banks with full flags and frame tags
module pingpong_ram import fft_buf_pkg::*; #(
    parameter int FFT_SIZE = DEF_FFT_SIZE,
    localparam int ADDR_W  = $clog2(FFT_SIZE)
) (
    input  logic              clk,
    input  logic              rst,
    // write side from the cp remover
    input  logic              wr_en,
    input  logic              wr_done,
    input  logic              wr_frm,
    input  bank_t             wr_bank,
    input  logic [ADDR_W-1:0] wr_addr,
    input  sample_t           wr_data,
    // read side from the feeder
    input  logic              rd_en,
    input  logic              rd_done,
    input  bank_t             rd_bank,
    input  logic [ADDR_W-1:0] rd_addr,
    output sample_t           rd_data,      // one cycle after rd_en
    output logic              rd_frm,       // tag of the bank being read
    output logic [1:0]        bank_full
);

    sample_t    mem [2][FFT_SIZE];          // bank-major storage
    logic [1:0] frm_tag;                    // symbol of this bank opened a frame

    // simple dual port, read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_bank][wr_addr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_bank][rd_addr];
            rd_frm  <= frm_tag[rd_bank];
        end
    end

    // full flags
    // set by the last write, cleared by the last read
    // writer and reader never finish the same bank on one edge
    always_ff @(posedge clk) begin
        if (rst) begin
            bank_full <= 2'b00;
            frm_tag   <= 2'b00;
        end else begin
            if (wr_done) begin
                bank_full[wr_bank] <= 1'b1;
                frm_tag[wr_bank]   <= wr_frm;   // tag travels with the bank
            end
            if (rd_done)
                bank_full[rd_bank] <= 1'b0;
        end
    end

    // the cp remover must have discarded anything aimed at a full bank
    a_wr_not_full: assert property (
        @(posedge clk) disable iff (rst) wr_en |-> !bank_full[wr_bank]
    );

    // the feeder only walks a bank that holds a complete symbol
    a_rd_full: assert property (
        @(posedge clk) disable iff (rst) rd_en |-> bank_full[rd_bank]
    );

endmodule

`default_nettype wire

//--- tb_fft_buf.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the cp strip / ping-pong fft input buffer, small symbol geometry
module tb_fft_buf import fft_buf_pkg::*; ();
    localparam int FFT_SIZE = 16;
    localparam int CP_FIRST = 6;
    localparam int CP_NORM  = 4;
    localparam int CREDITS  = 4;
    localparam int TIMEOUT  = 3000;      // cycles allowed per wait
    localparam int W_DRAIN  = 0;         // wait selectors
    localparam int W_ROOM   = 1;
    localparam int W_OWED   = 2;
    localparam int W_OVF    = 3;

    logic    clk;
    logic    rst;
    logic    in_valid, in_sym_start, in_frm_start;
    sample_t in_data;
    logic    out_credit = 1'b0;
    logic    out_valid, out_sop, out_eop, out_frm_start, overflow;
    sample_t out_data;

    logic [34:0] exp_q[$];               // {frm, sop, eop, data} per kept sample
    int      n_acc = 0;                  // symbols taken into the model
    int      n_drn = 0;                  // symbols fully seen at the output
    int      n_out = 0;                  // out_valid cycles
    int      n_ret = 0;                  // credits handed back
    int      owed = 0;                   // samples received, slot not yet returned
    int      credit_mode = 0;            // 0 withhold, 1 random, 2 whenever owed
    int      errors = 0;
    int      test_err = 0;
    int      n_tests = 0;
    int      n_failed = 0;
    int      snap;
    bit      quiet_chk = 1'b0;
    bit      ovf_expected = 1'b0;
    integer  seed = 32'h258806db;
    logic [7:0] frm_id = 8'h00;
    logic [7:0] sym_id = 8'h00;

    fft_buf_top #(
        .FFT_SIZE(FFT_SIZE), .CP_FIRST(CP_FIRST), .CP_NORM(CP_NORM), .CREDITS(CREDITS)
    ) u_dut (
        .clk, .rst, .in_valid, .in_data, .in_sym_start, .in_frm_start, .out_credit,
        .out_valid, .out_data, .out_sop, .out_eop, .out_frm_start, .overflow
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic note_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act)
            else note_error($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    // output monitor, pops the model in order
    always @(posedge clk) begin
        logic [34:0] w;
        if (!rst && out_valid) begin
            n_out++;
            if (exp_q.size() == 0) begin
                note_error("an output sample arrived with no symbol left in the model");
            end else begin
                w = exp_q.pop_front();
                check_value("out_data", w[31:0], out_data);
                check_value("out_sop", 32'(w[33]), 32'(out_sop));
                check_value("out_eop", 32'(w[32]), 32'(out_eop));
                check_value("out_frm_start", 32'(w[34]), 32'(out_frm_start));
                if (w[32])
                    n_drn++;             // symbol left its bank
            end
        end
    end

    // fft side, returns one slot per sample already taken
    always @(posedge clk) begin
        logic give;
        if (rst) begin
            out_credit <= 1'b0;
            owed = 0;
        end else begin
            if (out_valid)
                owed++;
            case (credit_mode)
                1:       give = (owed > 0) && (($random(seed) & 1) == 1);
                2:       give = (owed > 0);
                default: give = 1'b0;
            endcase
            if (give) begin
                owed--;
                n_ret++;
            end
            out_credit <= give;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        quiet_chk |-> !(out_valid || out_sop || out_eop || out_frm_start || overflow))
        else note_error("an output or the overflow flag was active right after reset");
    a_frm_with_sop: assert property (@(posedge clk) disable iff (rst) out_frm_start |-> out_sop)
        else note_error("out_frm_start was high away from a symbol start");
    a_marks_valid: assert property (@(posedge clk) disable iff (rst)
        (out_sop || out_eop) |-> out_valid)
        else note_error("a symbol marker was high without out_valid");
    a_credit_bound: assert property (@(posedge clk) disable iff (rst) n_out <= CREDITS + n_ret)
        else note_error("the output delivered more samples than credits allowed");
    a_no_spurious_ovf: assert property (@(posedge clk) disable iff (rst)
        !ovf_expected |-> !overflow)
        else note_error("overflow rose while a bank was still free");

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid     <= 1'b0;
            in_sym_start <= 1'b0;
            in_frm_start <= 1'b0;
        end
    endtask

    // one symbol with its prefix, data tagged {frame, symbol, 0, index}
    task automatic send_symbol(input bit frm, input bit gaps);
        int      cp;
        bit      keep_sym;
        sample_t d;
        cp = frm ? CP_FIRST : CP_NORM;
        keep_sym = 1'b0;
        sym_id++;
        if (frm)
            frm_id++;
        for (int i = 0; i < cp + FFT_SIZE; i++) begin
            if (gaps && (($random(seed) & 3) == 0))
                idle(1);                 // stray idle cycle inside the symbol
            d = {frm_id, sym_id, 8'h00, 8'(i)};
            @(posedge clk);
            in_valid     <= 1'b1;
            in_sym_start <= (i == 0);
            in_frm_start <= frm && (i == 0);
            in_data      <= d;
            if (i == cp) begin
                keep_sym = (n_acc - n_drn) < 2;   // both banks busy means the target is full
                if (keep_sym)
                    n_acc++;
                else
                    ovf_expected = 1'b1;
            end
            if (keep_sym && i >= cp)
                exp_q.push_back({frm && (i == cp), i == cp, i == cp + FFT_SIZE - 1, d});
        end
    endtask

    function automatic bit cond_met(input int what);
        case (what)
            W_DRAIN: return exp_q.size() == 0;
            W_ROOM:  return (n_acc - n_drn) < 2;
            W_OWED:  return owed == 0;
            default: return overflow;
        endcase
    endfunction

    task automatic wait_until(input int what, input string desc);
        int cnt;
        cnt = 0;
        while (!cond_met(what) && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (!cond_met(what)) begin
            $display("timeout while waiting for %s", desc);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (errors == test_err) begin
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            n_failed++;
            $display("test %0d %s: %0d errors", n_tests, name, errors - test_err);
        end
        test_err = errors;
    endtask

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_sym_start = 1'b0;
        in_frm_start = 1'b0;
        in_data      = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        quiet_chk = 1'b1;                // nothing may move before input
        idle(20);
        quiet_chk = 1'b0;
        end_test("reset values");
        credit_mode = 1;
        repeat (3) begin
            wait_until(W_ROOM, "a free bank");
            send_symbol(1'b0, 1'b1);
        end
        idle(1);
        wait_until(W_DRAIN, "the normal symbols to drain");
        end_test("prefix removal");
        repeat (2) begin
            wait_until(W_ROOM, "a free bank");
            send_symbol(1'b1, 1'b1);     // long prefix, frame tag
            wait_until(W_ROOM, "a free bank");
            send_symbol(1'b0, 1'b1);
        end
        idle(1);
        wait_until(W_DRAIN, "the framed symbols to drain");
        end_test("frame first symbol");
        credit_mode = 2;                 // full rate, input never pauses
        send_symbol(1'b1, 1'b0);
        repeat (3) send_symbol(1'b0, 1'b0);
        idle(1);
        wait_until(W_DRAIN, "the back to back symbols to drain");
        end_test("back to back ping-pong");
        credit_mode = 0;
        send_symbol(1'b0, 1'b0);
        idle(30);
        snap = n_out;
        idle(40);
        assert (n_out == snap) else note_error("output kept running while credits were withheld");
        credit_mode = 1;
        wait_until(W_DRAIN, "the stalled symbol to drain");
        end_test("credit flow");
        credit_mode = 2;
        wait_until(W_OWED, "all credits to be returned");
        credit_mode = 0;
        idle(5);
        send_symbol(1'b1, 1'b0);
        send_symbol(1'b0, 1'b0);
        send_symbol(1'b0, 1'b0);         // both banks still full here
        idle(1);
        wait_until(W_OVF, "the overflow flag");
        assert (ovf_expected) else note_error("overflow was raised but no symbol was dropped");
        credit_mode = 1;
        wait_until(W_DRAIN, "the two buffered symbols to drain");
        idle(20);
        end_test("overflow");
        $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
